//--- hdl/st_mem_pkg.sv
`default_nettype none

package st_mem_pkg;

	// one 16 bit word on the memory bus
	typedef logic [15:0] word_t;
	// word address, byte address bits 23 to 1
	typedef logic [23:1] waddr_t;
	// ram size selection code
	typedef logic [2:0] mem_cfg_t;
	// bus slot number within the four slot cycle
	typedef logic [1:0] slot_t;

	// download queue depth, also the credits held at reset
	localparam int DL_DEPTH = 4;
	// credit counter has to hold 0 up to DL_DEPTH
	localparam int CREDIT_W = 3;
	// queue pointer width
	localparam int PTR_W = $clog2(DL_DEPTH);

	// ram size codes, any other code enables no ram
	localparam mem_cfg_t MEM_512K = 3'd0;
	localparam mem_cfg_t MEM_1M = 3'd1;
	localparam mem_cfg_t MEM_2M = 3'd2;
	localparam mem_cfg_t MEM_4M = 3'd3;
	localparam mem_cfg_t MEM_8M = 3'd4;
	localparam mem_cfg_t MEM_14M = 3'd5;

	// one rom or cartridge word from the io controller
	typedef struct packed {
		waddr_t addr;
		word_t data;
	} dl_word_t;

	// request towards the sdram controller
	typedef struct packed {
		logic req;
		logic we;
		logic uds;
		logic lds;
		waddr_t addr;
		word_t data;
	} mem_req_t;

	// chipset request, req is the ras falling pulse
	typedef struct packed {
		logic req;
		logic we;
		logic uds;
		logic lds;
		waddr_t addr;
		word_t data;
	} chip_req_t;

endpackage

`default_nettype wire

//--- hdl/rom_download.sv
`timescale 1ns/1ps
`default_nettype none

module rom_download (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  logic                 dl_strobe_i,
	input  st_mem_pkg::waddr_t   dl_addr_i,
	input  st_mem_pkg::word_t    dl_data_i,
	input  logic                 download_i,
	input  logic                 credit_i,
	output logic                 push_o,
	output st_mem_pkg::dl_word_t push_word_o,
	output logic                 tos192k_o
);
	import st_mem_pkg::*;

	// idle, or one word parked until a credit comes back
	typedef enum logic {
		DL_IDLE,
		DL_HOLD
	} dl_state_t;

	dl_state_t state_q;
	logic strobe_q;
	logic [CREDIT_W-1:0] credits_q;
	logic toggle;
	logic capture;
	logic issue;

	// every level change of the strobe carries a new word
	assign toggle = dl_strobe_i ^ strobe_q;
	// toggles seen while a word is parked are dropped
	assign capture = toggle && (state_q == DL_IDLE);
	// push needs a credit, parked word goes first
	assign issue = (credits_q != '0) && ((state_q == DL_HOLD) || toggle);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_q <= 1'b0;
			state_q <= DL_IDLE;
			push_o <= 1'b0;
			credits_q <= CREDIT_W'(DL_DEPTH);
		end else begin
			strobe_q <= dl_strobe_i;
			// push is seen by the queue on the next edge
			push_o <= issue;
			// one credit spent per push, one returned per pop
			credits_q <= credits_q + CREDIT_W'(credit_i) - CREDIT_W'(issue);
			if (issue) begin
				state_q <= DL_IDLE;
			end else if (capture) begin
				// no credit left, park the word
				state_q <= DL_HOLD;
			end
		end
	end

	// output word doubles as the holding register
	always_ff @(posedge clk_32) begin
		if (capture) begin
			push_word_o.addr <= dl_addr_i;
			push_word_o.data <= dl_data_i;
		end
	end

	// 192k tos lives at $fc0000, the 256k ones at $e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (download_i) begin
			if (dl_addr_i[23:18] == 6'b111111) begin
				tos192k_o <= 1'b1;
			end else if (dl_addr_i[23:20] == 4'he) begin
				tos192k_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/download_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module download_fifo (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  logic                 push_i,
	input  st_mem_pkg::dl_word_t push_word_i,
	input  logic                 pop_i,
	output st_mem_pkg::dl_word_t head_o,
	output logic                 empty_o,
	output logic                 credit_o
);
	import st_mem_pkg::*;

	// entry storage
	dl_word_t mem_q [DL_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	// occupancy, 0 up to DL_DEPTH
	logic [PTR_W:0] count_q;
	logic do_pop;

	assign empty_o = (count_q == '0);
	// ignore a pop on an empty queue
	assign do_pop = pop_i && !empty_o;
	// head shows the oldest entry
	assign head_o = mem_q[rd_ptr_q];
	// freed entry goes straight back to the producer
	assign credit_o = do_pop;

	// no full check, producer credits keep it from overflowing
	always_ff @(posedge clk_32) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= push_word_i;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			// circular pointers wrap after the last entry
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DL_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DL_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// push and pop together leave the count alone
			case ({push_i, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/sdram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_mux (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  download_i,
	input  logic                  turbo_i,
	input  st_mem_pkg::mem_cfg_t  mem_cfg_i,
	input  st_mem_pkg::chip_req_t chip_req_i,
	input  logic                  empty_i,
	input  st_mem_pkg::dl_word_t  head_i,
	input  logic                  tos192k_i,
	input  logic                  rom_oe_i,
	input  st_mem_pkg::waddr_t    rom_bus_addr_i,
	output logic                  pop_o,
	output st_mem_pkg::mem_req_t  mem_req_o,
	output st_mem_pkg::waddr_t    rom_addr_o
);
	import st_mem_pkg::*;

	slot_t slot_q;
	logic cpu_slot;
	waddr_t chip_a;
	logic ram_en;
	logic chip_hit;
	mem_req_t sel_d;
	mem_req_t beat_q;
	logic req_q;
	logic rom_win;

	// free running four slot bus cycle
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			slot_q <= '0;
		end else begin
			slot_q <= slot_q + 1'b1;
		end
	end

	// cpu owns slot 1, turbo bus moves it to slot 2
	assign cpu_slot = turbo_i ? (slot_q == 2'd2) : (slot_q == 2'd1);

	// downloads take the cpu slot while words are queued
	assign pop_o = download_i && cpu_slot && !empty_i;

	assign chip_a = chip_req_i.addr;

	// ram size decode on the chipset address
	always_comb begin
		case (mem_cfg_i)
			MEM_512K: ram_en = (chip_a[23:19] == 5'b00000);
			MEM_1M: ram_en = (chip_a[23:20] == 4'b0000);
			MEM_2M: ram_en = (chip_a[23:21] == 3'b000);
			MEM_4M: ram_en = (chip_a[23:22] == 2'b00);
			MEM_8M: ram_en = !chip_a[23];
			// 14M stops below the $e00000 rom area
			MEM_14M: ram_en = (chip_a[23:21] != 3'b111);
			default: ram_en = 1'b0;
		endcase
	end

	// chipset is locked out during a download
	assign chip_hit = !download_i && chip_req_i.req && ram_en;

	// request selection
	always_comb begin
		sel_d = '0;
		if (pop_o) begin
			// download words are full word writes
			sel_d.req = 1'b1;
			sel_d.we = 1'b1;
			sel_d.uds = 1'b1;
			sel_d.lds = 1'b1;
			sel_d.addr = head_i.addr;
			sel_d.data = head_i.data;
		end else if (chip_hit) begin
			sel_d.req = 1'b1;
			sel_d.we = chip_req_i.we;
			sel_d.uds = chip_req_i.uds;
			sel_d.lds = chip_req_i.lds;
			sel_d.addr = chip_req_i.addr;
			sel_d.data = chip_req_i.data;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			req_q <= 1'b0;
		end else begin
			req_q <= sel_d.req;
		end
	end

	// fields only load with a real request
	always_ff @(posedge clk_32) begin
		if (sel_d.req) begin
			beat_q <= sel_d;
		end
	end

	always_comb begin
		mem_req_o = beat_q;
		mem_req_o.req = req_q;
	end

	// rom window $fc0000 to $feffff
	assign rom_win = rom_oe_i && (rom_bus_addr_i[23:18] == 6'b111111) &&
		(rom_bus_addr_i[23:16] != 8'hff);

	// keep bits 17..1, rebase to $fc0000 or $e00000
	always_comb begin
		rom_addr_o = rom_bus_addr_i;
		if (rom_win) begin
			rom_addr_o[23:18] = tos192k_i ? 6'b111111 : 6'b111000;
		end
	end

endmodule

`default_nettype wire

//--- hdl/st_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module st_mem_subsys (
	input  logic                  clk_32,
	input  logic                  xsint,
	// io controller download
	input  logic                  dl_strobe_i,
	input  st_mem_pkg::waddr_t    dl_addr_i,
	input  st_mem_pkg::word_t     dl_data_i,
	input  logic                  download_i,
	// configuration
	input  st_mem_pkg::mem_cfg_t  mem_cfg_i,
	input  logic                  turbo_i,
	// chipset side
	input  st_mem_pkg::chip_req_t chip_req_i,
	input  logic                  rom_oe_i,
	input  st_mem_pkg::waddr_t    rom_bus_addr_i,
	// sdram side
	output st_mem_pkg::mem_req_t  mem_req_o,
	output st_mem_pkg::waddr_t    rom_addr_o,
	output logic                  tos192k_o
);
	import st_mem_pkg::*;

	// capture to queue
	logic push;
	dl_word_t push_word;
	// queue back to capture
	logic credit;
	// queue to mux
	logic pop;
	dl_word_t head;
	logic empty;

	// strobe capture, credits and tos size flag
	rom_download rom_download0 (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.dl_strobe_i (dl_strobe_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.download_i  (download_i),
		.credit_i    (credit),
		.push_o      (push),
		.push_word_o (push_word),
		.tos192k_o   (tos192k_o)
	);

	download_fifo download_fifo0 (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.push_i      (push),
		.push_word_i (push_word),
		.pop_i       (pop),
		.head_o      (head),
		.empty_o     (empty),
		.credit_o    (credit)
	);

	// slot timing, ram decode and rom remap
	sdram_port_mux sdram_port_mux0 (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.download_i     (download_i),
		.turbo_i        (turbo_i),
		.mem_cfg_i      (mem_cfg_i),
		.chip_req_i     (chip_req_i),
		.empty_i        (empty),
		.head_i         (head),
		.tos192k_i      (tos192k_o),
		.rom_oe_i       (rom_oe_i),
		.rom_bus_addr_i (rom_bus_addr_i),
		.pop_o          (pop),
		.mem_req_o      (mem_req_o),
		.rom_addr_o     (rom_addr_o)
	);

endmodule

`default_nettype wire

//--- dv/st_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module st_mem_checker (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  dl_strobe_i,
	input  st_mem_pkg::waddr_t    dl_addr_i,
	input  st_mem_pkg::word_t     dl_data_i,
	input  logic                  download_i,
	input  st_mem_pkg::mem_cfg_t  mem_cfg_i,
	input  st_mem_pkg::chip_req_t chip_req_i,
	input  st_mem_pkg::mem_req_t  mem_req_i,
	input  st_mem_pkg::waddr_t    rom_addr_i,
	input  logic                  tos192k_i,
	input  logic                  check_rom_i,
	input  st_mem_pkg::waddr_t    exp_rom_i,
	input  logic                  check_chip_i,
	input  logic                  exp_hit_i,
	output int                    errors_o,
	output int                    pending_o
);
	import st_mem_pkg::*;

	// download writes still owed, oldest first
	mem_req_t dl_q [$];
	// chipset beat owed on the next edge
	mem_req_t chip_exp;
	logic chip_due = 1'b0;
	logic strobe_q = 1'b0;
	logic tos_model = 1'b0;
	logic hit;
	int err_cnt = 0;
	int pend_cnt = 0;

	assign errors_o = err_cnt;
	assign pending_o = pend_cnt;

	// ram ranges as byte address limits
	function automatic logic in_ram(mem_cfg_t cfg, waddr_t a);
		logic [23:0] b;
		b = {a, 1'b0};
		case (cfg)
			MEM_512K: return b < 24'h080000;
			MEM_1M: return b < 24'h100000;
			MEM_2M: return b < 24'h200000;
			MEM_4M: return b < 24'h400000;
			MEM_8M: return b < 24'h800000;
			MEM_14M: return b < 24'he00000;
			default: return 1'b0;
		endcase
	endfunction

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_beat(mem_req_t exp);
		compare("mem_req_o.we", mem_req_i.we, exp.we);
		compare("mem_req_o.uds", mem_req_i.uds, exp.uds);
		compare("mem_req_o.lds", mem_req_i.lds, exp.lds);
		compare("mem_req_o.addr", mem_req_i.addr, exp.addr);
		compare("mem_req_o.data", mem_req_i.data, exp.data);
	endtask

	always @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			dl_q.delete();
			chip_due = 1'b0;
			strobe_q = 1'b0;
			tos_model = 1'b0;
		end else begin
			// outputs here still show the previous cycle
			compare("tos192k_o", tos192k_i, tos_model);
			if (check_rom_i) begin
				compare("rom_addr_o", rom_addr_i, exp_rom_i);
			end
			if (mem_req_i.req) begin
				if (chip_due) begin
					check_beat(chip_exp);
				end else if (dl_q.size() > 0) begin
					check_beat(dl_q.pop_front());
				end else begin
					$display("unexpected request on mem_req_o at address %h", mem_req_i.addr);
					err_cnt++;
				end
			end else if (chip_due) begin
				$display("chipset request to %h was not passed on", chip_exp.addr);
				err_cnt++;
			end
			// each strobe toggle owes one full word write
			if (dl_strobe_i != strobe_q) begin
				dl_q.push_back({1'b1, 1'b1, 1'b1, 1'b1, dl_addr_i, dl_data_i});
			end
			strobe_q = dl_strobe_i;
			// chipset passes only outside downloads and inside the ram
			hit = chip_req_i.req && !download_i && in_ram(mem_cfg_i, chip_req_i.addr);
			if (check_chip_i && (hit != exp_hit_i)) begin
				$display("stimulus table expects chipset hit %0b, ram range rule gives %0b",
					exp_hit_i, hit);
				err_cnt++;
			end
			chip_due = hit;
			chip_exp = mem_req_t'(chip_req_i);
			// 192k tos at the top megabytes, 256k tos at $e0
			if (download_i) begin
				if (dl_addr_i[23:18] == 6'h3f) begin
					tos_model = 1'b1;
				end else if (dl_addr_i[23:20] == 4'he) begin
					tos_model = 1'b0;
				end
			end
		end
		pend_cnt = dl_q.size() + int'(chip_due);
	end

endmodule

`default_nettype wire

//--- dv/tb_st_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_st_mem;
	import st_mem_pkg::*;

	// row kinds
	localparam logic [2:0] K_IDLE = 3'd0;
	localparam logic [2:0] K_DL = 3'd1;
	localparam logic [2:0] K_CHIP = 3'd2;
	localparam logic [2:0] K_ROM = 3'd3;
	localparam logic [2:0] K_ROM_OFF = 3'd4;
	localparam int DRAIN_LIMIT = 200;

	// addr and exp hold byte addresses
	// bit 0 of exp is the hit bit of chipset rows
	typedef struct packed {
		logic [2:0] kind;
		logic [23:0] addr;
		word_t data;
		mem_cfg_t cfg;
		logic turbo;
		logic dl;
		logic [23:0] exp;
	} row_t;

	row_t rows [$];
	logic clk_32;
	logic xsint;
	logic dl_strobe;
	waddr_t dl_addr;
	word_t dl_data;
	logic download;
	mem_cfg_t mem_cfg;
	logic turbo;
	chip_req_t chip_req;
	logic rom_oe;
	waddr_t rom_bus_addr;
	mem_req_t mem_req;
	waddr_t rom_addr;
	logic tos192k;
	logic check_rom;
	logic check_chip;
	waddr_t exp_rom;
	logic exp_hit;
	int errors;
	int pending;
	int timeouts;

	st_mem_subsys dut0 (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.dl_strobe_i    (dl_strobe),
		.dl_addr_i      (dl_addr),
		.dl_data_i      (dl_data),
		.download_i     (download),
		.mem_cfg_i      (mem_cfg),
		.turbo_i        (turbo),
		.chip_req_i     (chip_req),
		.rom_oe_i       (rom_oe),
		.rom_bus_addr_i (rom_bus_addr),
		.mem_req_o      (mem_req),
		.rom_addr_o     (rom_addr),
		.tos192k_o      (tos192k)
	);

	st_mem_checker st_mem_checker (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.dl_strobe_i    (dl_strobe),
		.dl_addr_i      (dl_addr),
		.dl_data_i      (dl_data),
		.download_i     (download),
		.mem_cfg_i      (mem_cfg),
		.chip_req_i     (chip_req),
		.mem_req_i      (mem_req),
		.rom_addr_i     (rom_addr),
		.tos192k_i      (tos192k),
		.check_rom_i    (check_rom),
		.exp_rom_i      (exp_rom),
		.check_chip_i   (check_chip),
		.exp_hit_i      (exp_hit),
		.errors_o       (errors),
		.pending_o      (pending)
	);

	initial clk_32 = 1'b0;
	always #2 clk_32 = ~clk_32;

	function automatic void add_row(logic [2:0] kind, logic [23:0] addr, mem_cfg_t cfg,
		logic turbo_v, logic dl_v, logic [23:0] exp);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.data = word_t'($urandom);
		r.cfg = cfg;
		r.turbo = turbo_v;
		r.dl = dl_v;
		r.exp = exp;
		rows.push_back(r);
	endfunction

	function automatic void build_table();
		int i;
		// two bursts deeper than the queue
		// turbo off for the first and on for the second
		for (i = 0; i < 8; i++) begin
			add_row(K_DL, 24'h000100 + 24'(i * 2), MEM_4M, 1'b0, 1'b1, 24'h0);
		end
		for (i = 0; i < 8; i++) begin
			add_row(K_DL, 24'h020200 + 24'(i * 2), MEM_4M, 1'b1, 1'b1, 24'h0);
		end
		// last word inside each size and first word past it
		add_row(K_CHIP, 24'h07fffe, MEM_512K, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'h080000, MEM_512K, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'h0ffffe, MEM_1M, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'h100000, MEM_1M, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'h1ffffe, MEM_2M, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'h200000, MEM_2M, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'h3ffffe, MEM_4M, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'h400000, MEM_4M, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'h7ffffe, MEM_8M, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'h800000, MEM_8M, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'hdffffe, MEM_14M, 1'b0, 1'b0, 24'h1);
		add_row(K_CHIP, 24'he00000, MEM_14M, 1'b0, 1'b0, 24'h0);
		add_row(K_CHIP, 24'h000000, 3'd6, 1'b0, 1'b0, 24'h0);
		// chipset locked out while downloading
		add_row(K_DL, 24'h004000, MEM_4M, 1'b0, 1'b1, 24'h0);
		add_row(K_CHIP, 24'h001000, MEM_4M, 1'b0, 1'b1, 24'h0);
		add_row(K_DL, 24'h004002, MEM_4M, 1'b0, 1'b1, 24'h0);
		add_row(K_CHIP, 24'h001002, MEM_4M, 1'b0, 1'b1, 24'h0);
		// tos size flag and rom remap
		add_row(K_DL, 24'hfc0000, MEM_4M, 1'b0, 1'b1, 24'h0);
		add_row(K_ROM, 24'hfd1234, MEM_4M, 1'b0, 1'b0, 24'hfd1234);
		add_row(K_DL, 24'he00000, MEM_4M, 1'b0, 1'b1, 24'h0);
		add_row(K_ROM, 24'hfd1234, MEM_4M, 1'b0, 1'b0, 24'he11234);
		add_row(K_ROM, 24'h123456, MEM_4M, 1'b0, 1'b0, 24'h123456);
		add_row(K_ROM, 24'hff0010, MEM_4M, 1'b0, 1'b0, 24'hff0010);
		add_row(K_ROM_OFF, 24'hfd1234, MEM_4M, 1'b0, 1'b0, 24'hfd1234);
		add_row(K_IDLE, 24'h000000, MEM_4M, 1'b0, 1'b0, 24'h0);
	endfunction

	// quiet cycles with no requests and no checks
	task automatic idle_cycles(int n);
		repeat (n) begin
			@(negedge clk_32);
			chip_req = '0;
			rom_oe = 1'b0;
			check_rom = 1'b0;
			check_chip = 1'b0;
		end
	endtask

	task automatic drive_row(row_t r);
		@(negedge clk_32);
		mem_cfg = r.cfg;
		turbo = r.turbo;
		download = r.dl;
		chip_req = '0;
		rom_oe = 1'b0;
		check_rom = 1'b0;
		check_chip = 1'b0;
		rom_bus_addr = r.addr[23:1];
		exp_rom = r.exp[23:1];
		exp_hit = r.exp[0];
		case (r.kind)
			K_DL: begin
				dl_addr = r.addr[23:1];
				dl_data = r.data;
				dl_strobe = ~dl_strobe;
			end
			K_CHIP: begin
				chip_req.req = 1'b1;
				chip_req.we = r.data[0];
				chip_req.uds = 1'b1;
				chip_req.lds = r.data[1];
				chip_req.addr = r.addr[23:1];
				chip_req.data = r.data;
				check_chip = 1'b1;
			end
			K_ROM: begin
				rom_oe = 1'b1;
				check_rom = 1'b1;
			end
			K_ROM_OFF: check_rom = 1'b1;
			default: ;
		endcase
	endtask

	// wait until every owed request has come out
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk_32);
			n++;
		end
		if (pending != 0) begin
			$display("timeout: %0d requests still outstanding after %0d cycles",
				pending, DRAIN_LIMIT);
			timeouts++;
		end
	endtask

	initial begin
		void'($urandom(32'hce8b));
		timeouts = 0;
		xsint = 1'b0;
		dl_strobe = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		download = 1'b0;
		mem_cfg = MEM_4M;
		turbo = 1'b0;
		chip_req = '0;
		rom_oe = 1'b0;
		rom_bus_addr = '0;
		check_rom = 1'b0;
		check_chip = 1'b0;
		exp_rom = '0;
		exp_hit = 1'b0;
		build_table();
		repeat (5) @(posedge clk_32);
		@(negedge clk_32);
		xsint = 1'b1;
		foreach (rows[i]) begin
			// queue has to be empty before download drops
			if (!rows[i].dl && download) begin
				idle_cycles(1);
				wait_drain();
			end
			drive_row(rows[i]);
			// strobe pacing
			if (rows[i].kind == K_DL) begin
				idle_cycles(7);
			end
		end
		idle_cycles(1);
		wait_drain();
		idle_cycles(4);
		$display("errors: %0d from checker, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/st_mem_pkg.sv
hdl/rom_download.sv
hdl/download_fifo.sv
hdl/sdram_port_mux.sv
hdl/st_mem_subsys.sv
dv/st_mem_checker.sv
dv/tb_st_mem.sv
